/* Bender.yml */
package:
  name: burst_master

sources:
  - verilog/burst_pkg.sv
  - verilog/cmd_intake.sv
  - verilog/addr_issue.sv
  - verilog/wr_beat_gen.sv
  - verilog/rd_collect.sv
  - verilog/burst_master_top.sv
  - target: simulation
    files:
      - sim/axi_slave_model.sv
      - sim/burst_master_tb.sv

/* sim/axi_slave_model.sv */
`timescale 1ns/1ps

module axi_slave_model (
    input  logic                       clk,
    input  logic                       rst,
    input  burst_pkg::addr_beat_t      wr_addr,
    input  logic                       wr_addr_valid,
    output logic                       wr_addr_ready,
    input  burst_pkg::wr_beat_t        wr_data,
    input  logic                       wr_data_valid,
    output logic                       wr_data_ready,
    output logic [burst_pkg::id_w-1:0] wr_back_id,
    input  burst_pkg::addr_beat_t      rd_addr,
    input  logic                       rd_addr_valid,
    output logic                       rd_addr_ready,
    output burst_pkg::rd_beat_t        rd_data,
    output logic                       rd_data_valid,
    input  logic                       rd_data_ready,
    input  logic                       corrupt_id,
    input  int                         early_last,  // beat index with a forced last, -1 for none
    input  int                         stall        // idle cycles before each ready or valid
);

    import burst_pkg::*;

    logic [data_w-1:0] mem [0:255];  // word memory, index is addr[9:2]
    int                wa_cnt;
    int                wd_cnt;
    int                ra_cnt;
    int                rd_cnt;
    logic [7:0]        wr_ptr;
    logic [7:0]        rd_ptr;
    logic [id_w-1:0]   wr_id;
    logic [id_w-1:0]   rd_id;
    logic [len_w-1:0]  rd_len;
    logic [len_w-1:0]  rd_beat;
    logic              rd_busy;

    assign wr_addr_ready = wr_addr_valid && (wa_cnt >= stall);
    assign wr_data_ready = wr_data_valid && (wd_cnt >= stall);
    assign rd_addr_ready = rd_addr_valid && !rd_busy && (ra_cnt >= stall);
    assign rd_data_valid = rd_busy && (rd_cnt >= stall);
    assign wr_back_id    = corrupt_id ? ~wr_id : wr_id;

    always_comb begin
        rd_data.data = mem[rd_ptr];
        rd_data.last = (rd_beat == rd_len) || (early_last == int'(rd_beat));
        rd_data.id   = corrupt_id ? ~rd_id : rd_id;
    end

    // stall counters restart after every transfer
    always @(posedge clk) begin
        if (rst) begin
            wa_cnt  <= 0;
            wd_cnt  <= 0;
            ra_cnt  <= 0;
            rd_cnt  <= 0;
            rd_busy <= 1'b0;
        end else begin
            wa_cnt <= (wr_addr_valid && !wr_addr_ready) ? wa_cnt + 1 : 0;
            wd_cnt <= (wr_data_valid && !wr_data_ready) ? wd_cnt + 1 : 0;
            ra_cnt <= (rd_addr_valid && !rd_addr_ready) ? ra_cnt + 1 : 0;
            rd_cnt <= (rd_busy && !(rd_data_valid && rd_data_ready)) ? rd_cnt + 1 : 0;
            if (rd_addr_valid && rd_addr_ready) begin
                rd_busy <= 1'b1;
            end else if (rd_data_valid && rd_data_ready && rd_data.last) begin
                rd_busy <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (wr_addr_valid && wr_addr_ready) begin
            wr_ptr <= wr_addr.addr[9:2];
            wr_id  <= wr_addr.id;
        end
        if (wr_data_valid && wr_data_ready) begin
            for (int b = 0; b < strb_w; b++) begin
                if (wr_data.strb[b]) mem[wr_ptr][8*b +: 8] <= wr_data.data[8*b +: 8];
            end
            wr_ptr <= wr_ptr + 8'd1;
        end
        if (rd_addr_valid && rd_addr_ready) begin
            rd_ptr  <= rd_addr.addr[9:2];
            rd_len  <= rd_addr.len;
            rd_id   <= rd_addr.id;
            rd_beat <= '0;
        end else if (rd_data_valid && rd_data_ready) begin
            rd_ptr  <= rd_ptr + 8'd1;
            rd_beat <= rd_beat + 1'b1;
        end
    end

endmodule

/* sim/burst_master_tb.sv */
`timescale 1ns/1ps

module burst_master_tb;

    import burst_pkg::*;

    localparam int wait_limit = 2000;  // cycles per handshake phase

    logic                clk;
    logic                rst;
    logic                req;
    burst_cmd_t          cmd;
    logic                ack;
    burst_status_t       status;
    addr_beat_t          wr_addr;
    logic                wr_addr_valid;
    logic                wr_addr_ready;
    wr_beat_t            wr_data;
    logic                wr_data_valid;
    logic                wr_data_ready;
    logic [id_w-1:0]     wr_back_id;
    addr_beat_t          rd_addr;
    logic                rd_addr_valid;
    logic                rd_addr_ready;
    rd_beat_t            rd_data;
    logic                rd_data_valid;
    logic                rd_data_ready;
    logic                corrupt_id;
    int                  early_last;
    int                  stall;
    logic [31:0]         lfsr;
    logic [7:0]          wr_beat_seen;
    int                  errors;
    int                  test_errs;
    int                  tests_run;
    int                  tests_bad;

    burst_master_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .cmd           (cmd),
        .ack           (ack),
        .status        (status),
        .wr_addr       (wr_addr),
        .wr_addr_valid (wr_addr_valid),
        .wr_addr_ready (wr_addr_ready),
        .wr_data       (wr_data),
        .wr_data_valid (wr_data_valid),
        .wr_data_ready (wr_data_ready),
        .wr_back_id    (wr_back_id),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready)
    );

    axi_slave_model slave (
        .clk           (clk),
        .rst           (rst),
        .wr_addr       (wr_addr),
        .wr_addr_valid (wr_addr_valid),
        .wr_addr_ready (wr_addr_ready),
        .wr_data       (wr_data),
        .wr_data_valid (wr_data_valid),
        .wr_data_ready (wr_data_ready),
        .wr_back_id    (wr_back_id),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .corrupt_id    (corrupt_id),
        .early_last    (early_last),
        .stall         (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // write address len and beat last checked against the command as they are accepted
    always @(negedge clk) begin
        if (wr_addr_valid && wr_addr_ready) begin
            check_value("wr_bus", "addr len", 32'(cmd.len), 32'(wr_addr.len));
            wr_beat_seen = '0;
        end
        if (wr_data_valid && wr_data_ready) begin
            check_value("wr_bus", "last", 32'(wr_beat_seen == cmd.len), 32'(wr_data.last));
            wr_beat_seen = wr_beat_seen + 8'd1;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
    endfunction

    function automatic logic [31:0] seed_sum(input logic [31:0] seed, input int len);
        logic [31:0] s;
        s = '0;
        for (int k = 0; k <= len; k++) s = s + seed + k;  // wraps at 32 bits
        return s;
    endfunction

    function automatic burst_cmd_t make_cmd(input burst_op_e op, input logic [1:0] id,
                                            input logic [31:0] addr, input logic [7:0] len,
                                            input logic [31:0] seed, input logic [3:0] strb);
        burst_cmd_t c;
        c.op        = op;
        c.id        = id;
        c.addr      = addr;
        c.len       = len;
        c.seed      = seed;
        c.last_strb = strb;
        return c;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    // four-phase handshake with status sampled while ack is high
    task automatic run_burst(input burst_cmd_t c, output burst_status_t st);
        int n;
        @(posedge clk);
        cmd <= c;
        req <= 1'b1;
        n = 0;
        while (ack !== 1'b1 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (ack !== 1'b1) begin
            stop_on_timeout("ack never rose after req");
        end else begin
            st = status;
            @(posedge clk);
            req <= 1'b0;
            @(negedge clk);
            assert (ack === 1'b1) else begin
                $display("ack did not stay high until req was seen low");
                errors++;
                test_errs++;
            end
            n = 0;
            while (ack !== 1'b0 && n < wait_limit) begin
                @(negedge clk);
                n++;
            end
            if (ack !== 1'b0) stop_on_timeout("ack stayed high after req was dropped");
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s %s expected %h actual %h", test, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_status(input string test, input burst_status_t st,
                                input logic [31:0] sum, input logic [31:0] beats,
                                input logic last_err, input logic id_err);
        check_value(test, "sum", sum, st.sum);
        check_value(test, "beats", beats, 32'(st.beats));
        check_value(test, "last_err", 32'(last_err), 32'(st.last_err));
        check_value(test, "id_err", 32'(id_err), 32'(st.id_err));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic write_read(input string name, input logic [31:0] addr,
                              input logic [31:0] seed, input logic [7:0] len);
        burst_status_t st;
        run_burst(make_cmd(op_write, 2'd1, addr, len, seed, 4'hf), st);
        check_status(name, st, 32'd0, len + 1, 1'b0, 1'b0);
        run_burst(make_cmd(op_read, 2'd2, addr, len, 32'd0, 4'hf), st);
        check_status(name, st, seed_sum(seed, len), len + 1, 1'b0, 1'b0);
    endtask

    task automatic write_status();
        burst_status_t st;
        run_burst(make_cmd(op_write, 2'd3, 32'h0e0, 8'd0, 32'h55aa_0001, 4'hf), st);
        check_status("write_status", st, 32'd0, 32'd1, 1'b0, 1'b0);
        end_test("write_status");
    endtask

    // each word is read back alone as a one-beat burst
    task automatic strobe_merge();
        burst_status_t st;
        logic [31:0]   seed;
        logic [31:0]   old_w;
        logic [31:0]   new_w;
        logic [7:0]    base;
        seed = 32'h1234_a5f0;
        base = 8'h40;
        run_burst(make_cmd(op_write, 2'd0, {22'd0, base, 2'b00}, 8'd3, seed, 4'b0011), st);
        for (int k = 0; k <= 3; k++) begin
            old_w = fill_word(base + k[7:0]);
            new_w = seed + k;
            run_burst(make_cmd(op_read, 2'd0, {22'd0, base + k[7:0], 2'b00}, 8'd0, 32'd0,
                               4'hf), st);
            check_value("last_strb", "word", (k == 3) ? {old_w[31:16], new_w[15:0]} : new_w,
                        st.sum);
        end
        end_test("last_strb");
    endtask

    task automatic id_mismatch();
        burst_status_t st;
        @(posedge clk);
        corrupt_id <= 1'b1;
        run_burst(make_cmd(op_write, 2'd1, 32'h200, 8'd2, 32'h0bad_0000, 4'hf), st);
        check_status("id_error", st, 32'd0, 32'd3, 1'b0, 1'b1);
        run_burst(make_cmd(op_read, 2'd1, 32'h200, 8'd2, 32'd0, 4'hf), st);
        check_status("id_error", st, seed_sum(32'h0bad_0000, 2), 32'd3, 1'b0, 1'b1);
        @(posedge clk);
        corrupt_id <= 1'b0;
        end_test("id_error");
    endtask

    task automatic early_last_read();
        burst_status_t st;
        run_burst(make_cmd(op_write, 2'd2, 32'h280, 8'd7, 32'h7000_0010, 4'hf), st);
        @(posedge clk);
        early_last <= 2;
        run_burst(make_cmd(op_read, 2'd2, 32'h280, 8'd7, 32'd0, 4'hf), st);
        check_status("early_last", st, seed_sum(32'h7000_0010, 2), 32'd3, 1'b1, 1'b0);
        @(posedge clk);
        early_last <= -1;
        end_test("early_last");
    endtask

    task automatic stalled_bursts();
        logic [7:0]  len;
        logic [31:0] seed;
        @(posedge clk);
        stall <= 6;
        for (int i = 0; i < 4; i++) begin
            len  = 8'(random_bits(4));
            seed = random_bits(32);
            write_read("back_pressure", 32'h300 + i * 32'h40, seed, len);
        end
        @(posedge clk);
        stall <= 0;
        end_test("back_pressure");
    endtask

    initial begin
        rst        = 1'b1;
        req        = 1'b0;
        cmd        = '0;
        corrupt_id = 1'b0;
        early_last = -1;
        stall      = 0;
        lfsr       = 32'haa56;
        errors     = 0;
        test_errs  = 0;
        tests_run  = 0;
        tests_bad  = 0;
        for (int i = 0; i < 256; i++) slave.mem[i] <= fill_word(i[7:0]);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        write_read("write_read", 32'h000, 32'hffff_fffc, 8'd7);  // sum wraps
        end_test("write_read");
        write_status();
        strobe_merge();
        id_mismatch();
        early_last_read();
        stalled_bursts();
        $display("tests run %0d, tests with errors %0d, failed checks %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/burst_pkg.sv
verilog/cmd_intake.sv
verilog/addr_issue.sv
verilog/wr_beat_gen.sv
verilog/rd_collect.sv
verilog/burst_master_top.sv
sim/axi_slave_model.sv
sim/burst_master_tb.sv

/* verilog/addr_issue.sv */
`timescale 1ns/1ps

module addr_issue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  burst_pkg::burst_cmd_t cur_cmd,
    output burst_pkg::addr_beat_t wr_addr,
    output logic                  wr_addr_valid,
    input  logic                  wr_addr_ready,
    output burst_pkg::addr_beat_t rd_addr,
    output logic                  rd_addr_valid,
    input  logic                  rd_addr_ready,
    output logic                  wr_go,
    output logic                  rd_go,
    output burst_pkg::burst_cmd_t burst
);

    import burst_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wr_addr,
        st_rd_addr
    } state_e;

    state_e     state;
    addr_beat_t addr_q;

    // same registered beat on both channels, the valid picks the one in use
    assign wr_addr       = addr_q;
    assign rd_addr       = addr_q;
    assign wr_addr_valid = (state == st_wr_addr);
    assign rd_addr_valid = (state == st_rd_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            wr_go <= 1'b0;
            rd_go <= 1'b0;
        end else begin
            wr_go <= 1'b0;
            rd_go <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= (cur_cmd.op == op_write) ? st_wr_addr : st_rd_addr;
                    end
                end
                st_wr_addr: begin
                    if (wr_addr_ready) begin
                        wr_go <= 1'b1;
                        state <= st_idle;
                    end
                end
                st_rd_addr: begin
                    if (rd_addr_ready) begin
                        rd_go <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            addr_q.addr <= cur_cmd.addr;
            addr_q.len  <= cur_cmd.len;
            addr_q.id   <= cur_cmd.id;
            burst       <= cur_cmd;  // kept for the data stage
        end
    end

endmodule

/* verilog/burst_master_top.sv */
`timescale 1ns/1ps

module burst_master_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  burst_pkg::burst_cmd_t      cmd,
    output logic                       ack,
    output burst_pkg::burst_status_t   status,
    output burst_pkg::addr_beat_t      wr_addr,
    output logic                       wr_addr_valid,
    input  logic                       wr_addr_ready,
    output burst_pkg::wr_beat_t        wr_data,
    output logic                       wr_data_valid,
    input  logic                       wr_data_ready,
    input  logic [burst_pkg::id_w-1:0] wr_back_id,
    output burst_pkg::addr_beat_t      rd_addr,
    output logic                       rd_addr_valid,
    input  logic                       rd_addr_ready,
    input  burst_pkg::rd_beat_t        rd_data,
    input  logic                       rd_data_valid,
    output logic                       rd_data_ready
);

    import burst_pkg::*;

    logic          start;
    burst_cmd_t    cur_cmd;
    burst_cmd_t    burst;
    logic          wr_go;
    logic          rd_go;
    logic          wr_done;
    logic          rd_done;
    logic          done;
    burst_status_t wr_status;
    burst_status_t rd_status;
    burst_status_t done_status;

    // only one data stage is active per burst
    assign done        = wr_done | rd_done;
    assign done_status = wr_done ? wr_status : rd_status;

    cmd_intake u_cmd_intake (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .cmd         (cmd),
        .ack         (ack),
        .status      (status),
        .start       (start),
        .cur_cmd     (cur_cmd),
        .done        (done),
        .done_status (done_status)
    );

    addr_issue u_addr_issue (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .cur_cmd       (cur_cmd),
        .wr_addr       (wr_addr),
        .wr_addr_valid (wr_addr_valid),
        .wr_addr_ready (wr_addr_ready),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .wr_go         (wr_go),
        .rd_go         (rd_go),
        .burst         (burst)
    );

    wr_beat_gen u_wr_beat_gen (
        .clk           (clk),
        .rst           (rst),
        .wr_go         (wr_go),
        .burst         (burst),
        .wr_data       (wr_data),
        .wr_data_valid (wr_data_valid),
        .wr_data_ready (wr_data_ready),
        .wr_back_id    (wr_back_id),
        .done          (wr_done),
        .status        (wr_status)
    );

    rd_collect u_rd_collect (
        .clk           (clk),
        .rst           (rst),
        .rd_go         (rd_go),
        .burst         (burst),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .done          (rd_done),
        .status        (rd_status)
    );

endmodule

/* verilog/burst_pkg.sv */
package burst_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int len_w  = 8;
    localparam int id_w   = 2;
    localparam int strb_w = 4;
    localparam int cnt_w  = len_w + 1;  // beat count, len + 1 can reach 256

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } burst_op_e;

    // one host command, len is beats minus one
    typedef struct packed {
        burst_op_e           op;
        logic [id_w-1:0]     id;
        logic [addr_w-1:0]   addr;
        logic [len_w-1:0]    len;
        logic [data_w-1:0]   seed;
        logic [strb_w-1:0]   last_strb;
    } burst_cmd_t;

    typedef struct packed {
        logic [data_w-1:0]   sum;       // zero for writes
        logic [cnt_w-1:0]    beats;
        logic                last_err;
        logic                id_err;
    } burst_status_t;

    typedef struct packed {
        logic [addr_w-1:0]   addr;
        logic [len_w-1:0]    len;
        logic [id_w-1:0]     id;
    } addr_beat_t;

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [strb_w-1:0]   strb;
        logic                last;
    } wr_beat_t;

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic                last;
        logic [id_w-1:0]     id;
    } rd_beat_t;

endpackage

/* verilog/cmd_intake.sv */
`timescale 1ns/1ps

module cmd_intake (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  burst_pkg::burst_cmd_t    cmd,
    output logic                     ack,
    output burst_pkg::burst_status_t status,
    output logic                     start,
    output burst_pkg::burst_cmd_t    cur_cmd,
    input  logic                     done,
    input  burst_pkg::burst_status_t done_status
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_acked,
        st_wait_low
    } state_e;

    state_e state;
    logic   take_cmd;

    assign take_cmd = (state == st_idle) && req && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            ack   <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (take_cmd) begin
                        start <= 1'b1;
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (done) begin
                        ack   <= 1'b1;
                        state <= st_acked;
                    end
                end
                st_acked: begin
                    if (!req) begin  // host has sampled status
                        ack   <= 1'b0;
                        state <= st_wait_low;
                    end
                end
                st_wait_low: state <= st_idle;  // ack is low now
                default:     state <= st_idle;
            endcase
        end
    end

    // command and result held steady for the whole handshake
    always_ff @(posedge clk) begin
        if (take_cmd) cur_cmd <= cmd;
        if (state == st_busy && done) status <= done_status;
    end

endmodule

/* verilog/rd_collect.sv */
`timescale 1ns/1ps

module rd_collect (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_go,
    input  burst_pkg::burst_cmd_t    burst,
    input  burst_pkg::rd_beat_t      rd_data,
    input  logic                     rd_data_valid,
    output logic                     rd_data_ready,
    output logic                     done,
    output burst_pkg::burst_status_t status
);

    import burst_pkg::*;

    typedef enum logic {
        st_idle,
        st_recv
    } state_e;

    state_e            state;
    logic [len_w-1:0]  cnt_q;
    logic [data_w-1:0] sum_q;
    logic              id_err_q;
    logic              beat_ok;
    logic              at_len;
    logic              finish;
    logic [data_w-1:0] sum_nxt;
    logic              id_err_nxt;
    logic              last_err_nxt;

    assign rd_data_ready = (state == st_recv);

    always_comb begin
        beat_ok      = rd_data_valid && rd_data_ready;
        at_len       = (cnt_q == burst.len);
        sum_nxt      = sum_q + rd_data.data;  // wraps at 32 bits
        id_err_nxt   = id_err_q | (rd_data.id != burst.id);
        last_err_nxt = rd_data.last ^ at_len;  // early last or missing last
        finish       = beat_ok && (rd_data.last || at_len);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: if (rd_go) state <= st_recv;
                st_recv: begin
                    if (finish) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && rd_go) begin
            cnt_q    <= '0;
            sum_q    <= '0;
            id_err_q <= 1'b0;
        end else if (beat_ok) begin
            cnt_q    <= cnt_q + 1'b1;
            sum_q    <= sum_nxt;
            id_err_q <= id_err_nxt;
        end
        if (finish) begin
            status.sum      <= sum_nxt;
            status.beats    <= {1'b0, cnt_q} + cnt_w'(1);
            status.last_err <= last_err_nxt;
            status.id_err   <= id_err_nxt;
        end
    end

endmodule

/* verilog/wr_beat_gen.sv */
`timescale 1ns/1ps

module wr_beat_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_go,
    input  burst_pkg::burst_cmd_t    burst,
    output burst_pkg::wr_beat_t      wr_data,
    output logic                     wr_data_valid,
    input  logic                     wr_data_ready,
    input  logic [burst_pkg::id_w-1:0] wr_back_id,
    output logic                     done,
    output burst_pkg::burst_status_t status
);

    import burst_pkg::*;

    typedef enum logic {
        st_idle,
        st_send
    } state_e;

    state_e            state;
    logic [len_w-1:0]  beat_q;
    logic [data_w-1:0] data_q;
    logic              last_beat;
    logic              beat_ok;

    assign last_beat     = (beat_q == burst.len);
    assign wr_data_valid = (state == st_send);
    assign beat_ok       = wr_data_valid && wr_data_ready;

    always_comb begin
        wr_data.data = data_q;
        wr_data.last = last_beat;
        wr_data.strb = last_beat ? burst.last_strb : {strb_w{1'b1}};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: if (wr_go) state <= st_send;
                st_send: begin
                    if (beat_ok && last_beat) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // beat k carries seed + k, held while ready is low
    always_ff @(posedge clk) begin
        if (state == st_idle && wr_go) begin
            beat_q <= '0;
            data_q <= burst.seed;
        end else if (beat_ok) begin
            beat_q <= beat_q + 1'b1;
            data_q <= data_q + 1'b1;
        end
        if (beat_ok && last_beat) begin
            status.sum      <= '0;
            status.beats    <= {1'b0, beat_q} + cnt_w'(1);
            status.last_err <= 1'b0;
            status.id_err   <= (wr_back_id != burst.id);  // no response channel
        end
    end

endmodule
